// ==== common/heapPkg.sv ====
/*
  Array heap shared definitions: host action codes, result status codes
  and the element operations used by the read-modify-write path
*/
package heapPkg;

  // --------------------------------------------------
  // Host actions, numbered as in the original heap
  // --------------------------------------------------
  typedef enum logic [7:0] {
    actIdle     = 8'd0,                           // No action, results hold
    actWrite    = 8'd2,                           // Write element, grow array
    actRead     = 8'd3,                           // Read element within bounds
    actSize     = 8'd4,                           // Current array size
    actPush     = 8'd14,                          // Append at array end
    actPop      = 8'd15,                          // Remove from array end
    actAlloc    = 8'd18,                          // New or reused array
    actFree     = 8'd19,                          // Return array to free stack
    actAdd      = 8'd20,                          // Element plus in
    actSubtract = 8'd22,                          // Element minus in
    actOr       = 8'd28,                          // Element or in
    actXor      = 8'd29,                          // Element xor in
    actAnd      = 8'd30                           // Element and in
  } actionT;

  // --------------------------------------------------
  // Result status
  // --------------------------------------------------
  typedef enum logic [3:0] {
    errNone         = 4'd0,                       // Action completed
    errNotAllocated = 4'd1,                       // Array number never issued
    errFreed        = 4'd2,                       // Issued but currently free
    errOutOfBounds  = 4'd3,                       // Index not below size
    errFull         = 4'd4,                       // Push at maximum length
    errEmpty        = 4'd5,                       // Pop from empty array
    errHeapFull     = 4'd6,                       // Every array in use
    errBadAction    = 4'd7                        // Unknown action code
  } errorT;

  // Operation applied between the stored element and in
  typedef enum logic [2:0] {
    opPass     = 3'd0,                            // Store in unchanged
    opAdd      = 3'd1,
    opSubtract = 3'd2,
    opAnd      = 3'd3,
    opOr       = 3'd4,
    opXor      = 3'd5
  } elementOpT;

endpackage

// ==== heapControl/heapControl.sv ====
/*
  Heap action controller. Decodes the host action, checks array access,
  drives the directory and element store enables and registers out/error.
*/
`timescale 1ns/1ps

module heapControl import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
) (
  input  logic                    clock,
  input  logic                    resetN,
  input  actionT                  action,
  input  logic [INDEX_BITS-1:0]   index,
  input  logic [DATA_BITS-1:0]    in,
  input  logic                    issued,         // Array below issue counter
  input  logic                    allocated,      // Array currently in use
  input  logic [INDEX_BITS:0]     size,           // Current array size
  input  logic [ADDRESS_BITS-1:0] newArray,       // Next allocation result
  input  logic                    heapFull,
  input  logic [DATA_BITS-1:0]    element,        // Addressed element now
  input  logic [DATA_BITS-1:0]    result,         // Element after elementOp
  output logic                    allocate,       // Single-cycle strobes
  output logic                    releaseArray,
  output logic                    sizeWrite,
  output logic [INDEX_BITS:0]     sizeValue,
  output logic [INDEX_BITS-1:0]   elementIndex,
  output elementOpT               elementOp,
  output logic                    elementWrite,
  output logic [DATA_BITS-1:0]    out,
  output errorT                   error
);

  localparam int MAX_LENGTH = 2**INDEX_BITS;      // Elements per array

  logic [INDEX_BITS:0]  indexWide;                // Index at size width
  logic [INDEX_BITS:0]  sizeBelow;                // Size minus one, for pop
  logic                 arrayFull;
  errorT                writableError;            // Issued, then allocated
  errorT                readableError;            // Adds index below size
  errorT                errorNext;
  logic [DATA_BITS-1:0] outNext;

  assign indexWide = {1'b0, index};
  assign sizeBelow = size - 1'b1;
  assign arrayFull = (size == MAX_LENGTH);

  // --------------------------------------------------
  // Access checks
  // --------------------------------------------------
  always_comb begin
    if (!issued)         writableError = errNotAllocated;
    else if (!allocated) writableError = errFreed;
    else                 writableError = errNone;
  end

  always_comb begin
    if (writableError != errNone) readableError = writableError;
    else if (indexWide >= size)   readableError = errOutOfBounds;
    else                          readableError = errNone;
  end

  // --------------------------------------------------
  // Action decode, enables only when checks pass
  // --------------------------------------------------
  always_comb begin
    allocate     = 1'b0;
    releaseArray = 1'b0;
    sizeWrite    = 1'b0;
    sizeValue    = size;
    elementIndex = index;
    elementOp    = opPass;
    elementWrite = 1'b0;
    errorNext    = errNone;
    outNext      = out;                           // Out holds on any error
    case (action)
      actWrite: begin
        errorNext = writableError;
        if (writableError == errNone) begin
          elementWrite = 1'b1;
          outNext      = in;
          if (indexWide >= size) begin            // Grow to cover the index
            sizeWrite = 1'b1;
            sizeValue = indexWide + 1'b1;
          end
        end
      end
      actRead: begin
        errorNext = readableError;
        if (readableError == errNone) outNext = element;
      end
      actSize: begin
        errorNext = writableError;
        if (writableError == errNone) outNext = DATA_BITS'(size);
      end
      actPush: begin
        if (writableError != errNone) errorNext = writableError;
        else if (arrayFull)           errorNext = errFull;
        else begin
          elementIndex = size[INDEX_BITS-1:0];    // Slot just past the end
          elementWrite = 1'b1;
          sizeWrite    = 1'b1;
          sizeValue    = size + 1'b1;
          outNext      = in;
        end
      end
      actPop: begin
        if (writableError != errNone) errorNext = writableError;
        else if (size == '0)          errorNext = errEmpty;
        else begin
          elementIndex = sizeBelow[INDEX_BITS-1:0];
          sizeWrite    = 1'b1;
          sizeValue    = sizeBelow;
          outNext      = element;                 // Last element leaves
        end
      end
      actAlloc: begin
        if (heapFull) errorNext = errHeapFull;
        else begin
          allocate = 1'b1;
          outNext  = DATA_BITS'(newArray);
        end
      end
      actFree: begin
        errorNext    = writableError;
        releaseArray = (writableError == errNone);
      end
      actAdd, actSubtract, actAnd, actOr, actXor: begin
        case (action)
          actAdd:      elementOp = opAdd;
          actSubtract: elementOp = opSubtract;
          actAnd:      elementOp = opAnd;
          actOr:       elementOp = opOr;
          default:     elementOp = opXor;
        endcase
        errorNext = readableError;
        if (readableError == errNone) begin
          elementWrite = 1'b1;
          outNext      = result;                  // New value returned
        end
      end
      actIdle: errorNext = error;                 // Nothing to do
      default: errorNext = errBadAction;
    endcase
  end

  // Result registers, idle leaves both untouched
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      out   <= '0;
      error <= errNone;
    end else if (action != actIdle) begin
      out   <= outNext;
      error <= errorNext;
    end
  end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the array heap testbench with Verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module arrayHeapTb -f sim.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== sim.f ====
+incdir+tb
common/heapPkg.sv
verilog/elementStore.sv
verilog/arrayDirectory.sv
heapControl/heapControl.sv
verilog/arrayHeap.sv
tb/arrayHeapTb.sv

// ==== tb/heapTasks.svh ====
/*
  Array heap testbench tasks. Shadow model of the directory and elements,
  plus action issue and result checks against it.
*/
`ifndef HEAP_TASKS_SVH
`define HEAP_TASKS_SVH

// Read-modify-write rule, 12-bit wrap
function automatic logic [11:0] opResult(input logic [7:0] code, input logic [11:0] a,
                                         input logic [11:0] b);
  case (code)
    actAdd:      return a + b;
    actSubtract: return a - b;
    actAnd:      return a & b;
    actOr:       return a | b;
    default:     return a ^ b;
  endcase
endfunction

// Actions on an array that passed the issued and allocated checks
task automatic applyAccess(input logic [7:0] code, input int arr, input int idx,
                           input logic [11:0] val);
  logic [11:0] cur;
  cur      = modelMem[arr][idx];
  modelErr = errNone;
  case (code)
    actWrite: begin
      modelMem[arr][idx] = val;
      if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;  // Grow to cover index
      modelOut = val;
    end
    actSize: modelOut = 12'(modelSize[arr]);
    actPush: begin
      if (modelSize[arr] == MAX_LENGTH) modelErr = errFull;
      else begin
        modelMem[arr][modelSize[arr]] = val;
        modelSize[arr]++;
        modelOut = val;
      end
    end
    actPop: begin
      if (modelSize[arr] == 0) modelErr = errEmpty;
      else begin
        modelSize[arr]--;
        modelOut = modelMem[arr][modelSize[arr]];  // Last element leaves
      end
    end
    actFree: begin
      modelFlag[arr] = 1'b0;
      freeList.push_back(arr);
    end
    default: begin                                // Read and element operations
      if (idx >= modelSize[arr]) modelErr = errOutOfBounds;
      else if (code == actRead) modelOut = cur;
      else begin
        modelOut           = opResult(code, cur, val);
        modelMem[arr][idx] = modelOut;
      end
    end
  endcase
endtask

// Predicts out and error for one action, idle changes nothing
task automatic predict(input logic [7:0] code, input int arr, input int idx,
                       input logic [11:0] val);
  errorT access;
  int    slot;
  if (arr >= modelIssued) access = errNotAllocated;
  else if (!modelFlag[arr]) access = errFreed;
  else access = errNone;
  case (code)
    actIdle: ;
    actAlloc: begin
      if (freeList.size() == 0 && modelIssued == ARRAYS) modelErr = errHeapFull;
      else begin
        if (freeList.size() != 0) slot = freeList.pop_back();  // Most recent free
        else begin
          slot = modelIssued;
          modelIssued++;
        end
        modelFlag[slot] = 1'b1;
        modelSize[slot] = 0;
        modelOut        = 12'(slot);
        modelErr        = errNone;
      end
    end
    actWrite, actRead, actSize, actPush, actPop, actFree,
    actAdd, actSubtract, actAnd, actOr, actXor: begin
      if (access != errNone) modelErr = access;  // Out holds
      else applyAccess(code, arr, idx, val);
    end
    default: modelErr = errBadAction;
  endcase
endtask

`endif

// ==== tb/arrayHeapTb.sv ====
/*
  Array heap testbench. Drives actions against a shadow model and checks
  every result, plus allocation, bounds, stack and idle behaviors.
*/
`timescale 1ns/1ps

module arrayHeapTb import heapPkg::*; ();

  localparam int ARRAYS     = 4;
  localparam int MAX_LENGTH = 4;
  localparam int EDGE_STEPS = 200;                // Half-ns polls per edge

  logic        clock;
  logic        resetN;
  actionT      action;
  logic [1:0]  array;
  logic [1:0]  index;
  logic [11:0] in;
  logic [11:0] out;
  errorT       error;

  // Shadow model state
  logic [11:0] modelMem [ARRAYS][MAX_LENGTH];
  int          modelSize [ARRAYS];
  bit          modelFlag [ARRAYS];
  int          modelIssued;
  int          freeList [$];                      // Freed arrays, LIFO
  logic [11:0] modelOut;
  errorT       modelErr;

  int edgeCount;
  int checkCount;
  int errorCount;

  arrayHeap #(.ADDRESS_BITS(2), .INDEX_BITS(2), .DATA_BITS(12)) dut (
    .clock(clock), .resetN(resetN), .action(action), .array(array),
    .index(index), .in(in), .out(out), .error(error)
  );

  `include "heapTasks.svh"

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) edgeCount <= edgeCount + 1;

  // --------------------------------------------------
  // Timing helpers
  // --------------------------------------------------
  task automatic waitEdge();                      // Returns 0.5 ns past the edge
    int startCount;
    int steps;
    startCount = edgeCount;
    steps      = 0;
    while (edgeCount == startCount && steps < EDGE_STEPS) begin
      #0.5;
      steps++;
    end
    if (edgeCount == startCount) begin
      $display("Timeout: no rising clock edge arrived within %0d polls", EDGE_STEPS);
      $display("TESTBENCH FAILED");
      $finish;
    end
  endtask

  task automatic applyReset();
    resetN = 1'b0;
    repeat (5) waitEdge();
    #1.5;                                         // Release 2 ns after the edge
    resetN      = 1'b1;
    modelIssued = 0;
    modelOut    = '0;
    modelErr    = errNone;
    freeList.delete();
    for (int a = 0; a < ARRAYS; a++) begin
      modelFlag[a] = 1'b0;
      modelSize[a] = 0;
    end
  endtask

  // Issue at edge + 2 ns, check at the next edge + 1 ns
  task automatic step(input logic [7:0] code, input int arr, input int idx,
                      input logic [11:0] val);
    action = actionT'(code);
    array  = 2'(arr);
    index  = 2'(idx);
    in     = val;
    predict(code, arr, idx, val);
    waitEdge();
    #0.5;
    checkCount++;
    assert (out === modelOut && error === modelErr) else begin
      errorCount++;
      $display("error at time %0t: action %0d array %0d index %0d gave %h %s, expected %h %s",
               $time, code, arr, idx, out, error.name(), modelOut, modelErr.name());
    end
    #1;
  endtask

  task automatic expectValue(input logic [11:0] value, input errorT status);
    checkCount++;
    assert (out === value && error === status) else begin
      errorCount++;
      $display("error at time %0t: out %h %s, expected %h %s",
               $time, out, error.name(), value, status.name());
    end
  endtask

  // --------------------------------------------------
  // Behaviors
  // --------------------------------------------------
  initial begin
    logic [11:0] pushed [4];
    logic [11:0] held;
    actionT      ops [5];
    void'($urandom(14));
    ops    = '{actAdd, actSubtract, actAnd, actOr, actXor};
    resetN = 1'b0;
    action = actIdle;
    array  = '0;
    index  = '0;
    in     = '0;
    applyReset();

    for (int k = 0; k < 4; k++) begin             // Fresh numbers in order
      step(actAlloc, 0, 0, 12'h0);
      expectValue(12'(k), errNone);
    end
    step(actAlloc, 0, 0, 12'h0);
    expectValue(12'd3, errHeapFull);

    step(actFree, 2, 0, 12'h0);
    step(actFree, 0, 0, 12'h0);
    step(actRead, 0, 0, 12'h0);
    expectValue(12'd3, errFreed);
    step(actAlloc, 0, 0, 12'h0);                  // Last freed comes back first
    expectValue(12'd0, errNone);
    step(actAlloc, 0, 0, 12'h0);
    expectValue(12'd2, errNone);
    applyReset();
    step(actSize, 1, 0, 12'h0);
    expectValue(12'd0, errNotAllocated);
    step(actWrite, 3, 1, 12'h5a5);
    expectValue(12'd0, errNotAllocated);

    step(actAlloc, 0, 0, 12'h0);
    held = 12'($urandom);
    step(actWrite, 0, 2, held);
    step(actRead, 0, 2, 12'h0);                   // Sees the previous write
    expectValue(held, errNone);
    step(actSize, 0, 0, 12'h0);
    expectValue(12'd3, errNone);
    step(actRead, 0, 3, 12'h0);
    expectValue(12'd3, errOutOfBounds);

    step(actAlloc, 0, 0, 12'h0);
    for (int k = 0; k < 4; k++) begin
      pushed[k] = 12'($urandom);
      step(actPush, 1, 0, pushed[k]);
    end
    step(actPush, 1, 0, 12'h123);
    expectValue(pushed[3], errFull);
    for (int k = 0; k < 4; k++) begin             // Reverse order out
      step(actPop, 1, 0, 12'h0);
      expectValue(pushed[3 - k], errNone);
    end
    step(actPop, 1, 0, 12'h0);
    expectValue(pushed[0], errEmpty);

    for (int k = 0; k < 5; k++) begin
      step(actWrite, 0, 1, 12'($urandom));
      step(ops[k], 0, 1, 12'($urandom));
      held = modelOut;
      step(actRead, 0, 1, 12'h0);
      expectValue(held, errNone);
    end

    step(8'd1, 0, 0, 12'h0);                      // Undefined code
    expectValue(held, errBadAction);
    step(actIdle, 0, 0, 12'h0);
    expectValue(held, errBadAction);
    step(8'd255, 2, 3, 12'hfff);
    expectValue(held, errBadAction);
    step(actSize, 1, 0, 12'h0);
    step(actIdle, 3, 2, 12'h0);
    expectValue(12'd0, errNone);

    $display("Checks run %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/arrayDirectory.sv ====
/*
  Array directory. Tracks which arrays are issued and allocated, their
  sizes, and a LIFO of freed arrays that allocation reuses first.
*/
`timescale 1ns/1ps

module arrayDirectory #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2
) (
  input  logic                    clock,
  input  logic                    resetN,
  input  logic [ADDRESS_BITS-1:0] array,          // Array under access
  input  logic                    allocate,       // Hand out newArray
  input  logic                    releaseArray,   // Free the current array
  input  logic                    sizeWrite,
  input  logic [INDEX_BITS:0]     sizeValue,
  output logic                    issued,
  output logic                    allocated,
  output logic [INDEX_BITS:0]     size,
  output logic [ADDRESS_BITS-1:0] newArray,
  output logic                    heapFull
);

  localparam int ARRAYS = 2**ADDRESS_BITS;

  logic [ARRAYS-1:0]       allocFlags;            // One bit per array
  logic [INDEX_BITS:0]     sizes [ARRAYS];
  logic [ADDRESS_BITS-1:0] freeStack [ARRAYS];    // Freed arrays, LIFO
  logic [ADDRESS_BITS:0]   stackTop;              // Entries on the stack
  logic [ADDRESS_BITS:0]   stackBelow;            // Index of top entry
  logic [ADDRESS_BITS:0]   issueCount;            // Never-issued boundary
  logic                    stackEmpty;

  assign stackEmpty = (stackTop == '0);
  assign stackBelow = stackTop - 1'b1;

  // --------------------------------------------------
  // Lookups for the current array
  // --------------------------------------------------
  assign issued    = ({1'b0, array} < issueCount);
  assign allocated = allocFlags[array];
  assign size      = sizes[array];
  assign heapFull  = stackEmpty && issueCount[ADDRESS_BITS]; // Counter at ARRAYS

  // Reuse the most recently freed array before issuing a fresh one
  assign newArray = stackEmpty ? issueCount[ADDRESS_BITS-1:0]
                               : freeStack[stackBelow[ADDRESS_BITS-1:0]];

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocFlags <= '0;
      stackTop   <= '0;
      issueCount <= '0;
    end else begin
      if (allocate) begin
        allocFlags[newArray] <= 1'b1;
        if (stackEmpty) issueCount <= issueCount + 1'b1;
        else            stackTop   <= stackBelow;   // Pop the reused entry
      end
      if (releaseArray) begin
        allocFlags[array] <= 1'b0;
        stackTop          <= stackTop + 1'b1;
      end
    end
  end

  // Sizes and stack contents
  always_ff @(posedge clock) begin
    if (allocate) sizes[newArray] <= '0;        // Fresh array is empty
    if (sizeWrite) sizes[array] <= sizeValue;
    if (releaseArray) freeStack[stackTop[ADDRESS_BITS-1:0]] <= array;
  end

endmodule

// ==== verilog/arrayHeap.sv ====
/*
  Array heap top level. Joins the action controller, the array directory
  and the element store. Results appear one cycle after each action.
*/
`timescale 1ns/1ps

module arrayHeap import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,                 // Array number width
  parameter int INDEX_BITS   = 2,                 // Element index width
  parameter int DATA_BITS    = 12                 // Element width
) (
  input  logic                    clock,
  input  logic                    resetN,         // Asynchronous, active low
  input  actionT                  action,         // Host action this cycle
  input  logic [ADDRESS_BITS-1:0] array,          // Array to work on
  input  logic [INDEX_BITS-1:0]   index,          // Element within array
  input  logic [DATA_BITS-1:0]    in,             // Operand or value to store
  output logic [DATA_BITS-1:0]    out,            // Registered result
  output errorT                   error           // Registered status
);

  // Directory handshake wires
  logic                    allocate;
  logic                    releaseArray;
  logic                    sizeWrite;
  logic [INDEX_BITS:0]     sizeValue;
  logic                    issued;
  logic                    allocated;
  logic [INDEX_BITS:0]     size;
  logic [ADDRESS_BITS-1:0] newArray;
  logic                    heapFull;

  // Element store wires
  logic [INDEX_BITS-1:0]   elementIndex;
  elementOpT               elementOp;
  logic                    elementWrite;
  logic [DATA_BITS-1:0]    element;
  logic [DATA_BITS-1:0]    result;

  heapControl #(
    .ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS), .DATA_BITS(DATA_BITS)
  ) control (
    .clock(clock), .resetN(resetN), .action(action), .index(index), .in(in),
    .issued(issued), .allocated(allocated), .size(size), .newArray(newArray),
    .heapFull(heapFull), .element(element), .result(result),
    .allocate(allocate), .releaseArray(releaseArray), .sizeWrite(sizeWrite),
    .sizeValue(sizeValue), .elementIndex(elementIndex), .elementOp(elementOp),
    .elementWrite(elementWrite), .out(out), .error(error)
  );

  arrayDirectory #(
    .ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS)
  ) directory (
    .clock(clock), .resetN(resetN), .array(array), .allocate(allocate),
    .releaseArray(releaseArray), .sizeWrite(sizeWrite), .sizeValue(sizeValue),
    .issued(issued), .allocated(allocated), .size(size), .newArray(newArray),
    .heapFull(heapFull)
  );

  elementStore #(
    .ADDRESS_BITS(ADDRESS_BITS), .INDEX_BITS(INDEX_BITS), .DATA_BITS(DATA_BITS)
  ) store (
    .clock(clock), .array(array), .elementIndex(elementIndex), .in(in),
    .elementOp(elementOp), .elementWrite(elementWrite), .element(element),
    .result(result)
  );

endmodule

// ==== verilog/elementStore.sv ====
/*
  Element store. One block of elements per array, read combinationally,
  with the read-modify-write operator feeding the write port.
*/
`timescale 1ns/1ps

module elementStore import heapPkg::*; #(
  parameter int ADDRESS_BITS = 2,
  parameter int INDEX_BITS   = 2,
  parameter int DATA_BITS    = 12
) (
  input  logic                    clock,
  input  logic [ADDRESS_BITS-1:0] array,
  input  logic [INDEX_BITS-1:0]   elementIndex,
  input  logic [DATA_BITS-1:0]    in,             // Operand or value to store
  input  elementOpT               elementOp,
  input  logic                    elementWrite,
  output logic [DATA_BITS-1:0]    element,        // Current stored value
  output logic [DATA_BITS-1:0]    result          // Value after elementOp
);

  localparam int ADDR_BITS = ADDRESS_BITS + INDEX_BITS;
  localparam int DEPTH     = 2**ADDR_BITS;        // Fixed block per array

  logic [DATA_BITS-1:0] memory [DEPTH];
  logic [ADDR_BITS-1:0] address;

  assign address = {array, elementIndex};        // Array selects the block
  assign element = memory[address];

  // --------------------------------------------------
  // Operator, wraps modulo 2**DATA_BITS
  // --------------------------------------------------
  always_comb begin
    case (elementOp)
      opAdd:      result = element + in;
      opSubtract: result = element - in;
      opAnd:      result = element & in;
      opOr:       result = element | in;
      opXor:      result = element ^ in;
      default:    result = in;                    // Plain store
    endcase
  end

  always_ff @(posedge clock) begin
    if (elementWrite) memory[address] <= result;
  end

endmodule
